// File: src.f
+incdir+include
verilog/tensor_sum_pkg.sv
verilog/float_adder.sv
verilog/stream_dispatcher.sv
verilog/partial_accumulator.sv
verilog/sum_combiner.sv
verilog/tensor_summation.sv
tests/tb_tensor_summation.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the tensor summation testbench with Verilator.
# Exits non-zero unless the log holds the pass message.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f src.f \
  --top-module tb_tensor_summation \
  -o tb_tensor_summation > build.log 2>&1 \
  && ./obj_dir/tb_tensor_summation > sim.log 2>&1 \
  || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "TESTBENCH PASSED" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

// File: tests/tb_tensor_summation.sv
`timescale 1ns/1ns
////////////////////////////////////////
// Testbench for the tensor summation
// engine, host side of all handshakes
////////////////////////////////////////
`include "tensor_sum_defs.svh"

module tb_tensor_summation;

  localparam int clk_half   = 50;
  // Longest wait for one handshake edge, in cycles
  localparam int edge_limit = 200;
  localparam int num_random = 8;
  localparam int max_len    = 12;
  // Items over all tests with random commands at full length
  localparam int max_items    = 1 + 8 + 6 + 5 + num_random * max_len;
  localparam int watch_cycles = max_items * 40 + 3000;

  logic                        CLK;
  logic                        RST;
  logic [`TS_LENGTH_WIDTH-1:0] length;
  logic                        start_req;
  logic                        start_ack;
  tensor_sum_pkg::float_t      data_in;
  logic                        data_req;
  logic                        data_ack;
  tensor_sum_pkg::float_t      sum_out;
  logic                        sum_req;
  logic                        sum_ack;

  int pass_count;
  int fail_count;
  int seed_val;
  // Items of the stream being sent
  int vals [0:63];
  int lens [0:num_random-1];

  tensor_summation i_tensor_summation (
    .CLK       (CLK),
    .RST       (RST),
    .length    (length),
    .start_req (start_req),
    .start_ack (start_ack),
    .data_in   (data_in),
    .data_req  (data_req),
    .data_ack  (data_ack),
    .sum_out   (sum_out),
    .sum_req   (sum_req),
    .sum_ack   (sum_ack)
  );

  initial begin
    CLK = 1'b0;
    forever #clk_half CLK = ~CLK;
  end

  // Watchdog sized from the item count
  initial begin
    repeat (watch_cycles) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the run did not finish", watch_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Small signed integer to float bits
  function automatic tensor_sum_pkg::float_t int_to_float(input int v);
    tensor_sum_pkg::float_t w;
    int mag;
    int msb;
    int i;
    w.bits = '0;
    mag    = (v < 0) ? -v : v;
    msb    = 0;
    if (mag != 0) begin
      // Leading one sets the exponent
      for (i = 0; i < 24; i++) begin
        if (mag[i]) begin
          msb = i;
        end
      end
      w.f.sign = (v < 0);
      w.f.exp  = 8'(`TS_EXP_BIAS + msb);
      // Hidden bit drops off the top
      w.f.mant = 23'(mag << (`TS_MANT_WIDTH - msb));
    end
    return w;
  endfunction

  // 0 start_ack, 1 data_ack, 2 sum_req
  function automatic logic line_value(input int which);
    case (which)
      0:       return start_ack;
      1:       return data_ack;
      default: return sum_req;
    endcase
  endfunction

  function automatic string line_name(input int which);
    case (which)
      0:       return "start_ack";
      1:       return "data_ack";
      default: return "sum_req";
    endcase
  endfunction

  task automatic compare_float(input string name, input tensor_sum_pkg::float_t got,
                               input tensor_sum_pkg::float_t want);
    if (got.bits !== want.bits) begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, name, got.bits, want.bits);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("Fail at %0t ns: %s got %b expected %b", $time, name, got, want);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  // Sampled at falling edges away from the DUT updates
  task automatic wait_level(input int which, input logic level);
    int   n;
    logic cur;
    n   = 0;
    cur = ~level;
    while (cur !== level && n < edge_limit) begin
      @(negedge CLK);
      cur = line_value(which);
      n++;
    end
    if (cur !== level) begin
      $display("Handshake stuck at %0t ns: %s never went to %b", $time, line_name(which),
               level);
      fail_count++;
    end
  endtask

  ////////////////////////////////////////
  // Host side handshakes
  ////////////////////////////////////////

  // start_req may already be up from an early request
  task automatic send_command(input int len);
    if (start_req !== 1'b1) begin
      @(posedge CLK);
      length    <= len[`TS_LENGTH_WIDTH-1:0];
      start_req <= 1'b1;
    end
    wait_level(0, 1'b1);
    @(posedge CLK);
    start_req <= 1'b0;
    wait_level(0, 1'b0);
  endtask

  task automatic send_items(input int len, input int max_gap);
    int i;
    int gap;
    for (i = 0; i < len; i++) begin
      gap = (max_gap > 0) ? int'($urandom_range(max_gap)) : 0;
      repeat (gap) @(posedge CLK);
      @(posedge CLK);
      data_in  <= int_to_float(vals[i]);
      data_req <= 1'b1;
      wait_level(1, 1'b1);
      @(posedge CLK);
      data_req <= 1'b0;
      wait_level(1, 1'b0);
    end
  endtask

  // Negative next_len means no early command
  task automatic take_result(input tensor_sum_pkg::float_t want, input int max_delay,
                             input int next_len);
    int delay;
    wait_level(2, 1'b1);
    compare_float("sum_out", sum_out, want);
    delay = (max_delay > 0) ? int'($urandom_range(max_delay)) : 0;
    if (next_len >= 0) begin
      @(posedge CLK);
      length    <= next_len[`TS_LENGTH_WIDTH-1:0];
      start_req <= 1'b1;
    end
    // Next command stays blocked during a slow ack
    repeat (delay) begin
      @(negedge CLK);
      compare_flag("sum_req", sum_req, 1'b1);
      if (next_len >= 0) begin
        compare_flag("start_ack", start_ack, 1'b0);
      end
    end
    @(posedge CLK);
    sum_ack <= 1'b1;
    wait_level(2, 1'b0);
    if (next_len >= 0) begin
      compare_flag("start_ack", start_ack, 1'b0);
    end
    @(posedge CLK);
    sum_ack <= 1'b0;
  endtask

  // Expected value is the plain integer sum
  task automatic run_sum(input int len, input int max_gap, input int max_delay,
                         input int next_len);
    int i;
    int total;
    total = 0;
    for (i = 0; i < len; i++) begin
      total += vals[i];
    end
    send_command(len);
    send_items(len, max_gap);
    take_result(int_to_float(total), max_delay, next_len);
  endtask

  task automatic report_test(input string name, input int fails_before);
    if (fail_count == fails_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d failed checks", name, fail_count - fails_before);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_levels();
    int fb;
    fb = fail_count;
    @(negedge CLK);
    compare_flag("start_ack", start_ack, 1'b0);
    compare_flag("data_ack", data_ack, 1'b0);
    compare_flag("sum_req", sum_req, 1'b0);
    report_test("reset levels", fb);
  endtask

  // Odd lane stays at +0
  task automatic single_item();
    int fb;
    fb      = fail_count;
    vals[0] = -834567;
    run_sum(1, 0, 0, -1);
    report_test("single item", fb);
  endtask

  task automatic eight_positive();
    int fb;
    int i;
    fb = fail_count;
    for (i = 0; i < 8; i++) begin
      vals[i] = 1000 * (i + 1) + 37 * i;
    end
    run_sum(8, 1, 2, -1);
    report_test("eight positive", fb);
  endtask

  task automatic mixed_signs();
    int fb;
    fb = fail_count;
    // Lanes hold +24 and -24
    vals[0] = 5;
    vals[1] = -3;
    vals[2] = 12;
    vals[3] = -14;
    vals[4] = 7;
    vals[5] = -7;
    run_sum(6, 0, 1, -1);
    // Total of -336
    vals[0] = -100;
    vals[1] = 40;
    vals[2] = -300;
    vals[3] = 25;
    vals[4] = -1;
    run_sum(5, 2, 0, -1);
    report_test("mixed signs", fb);
  endtask

  task automatic zero_length();
    int fb;
    fb = fail_count;
    run_sum(0, 0, 3, -1);
    report_test("zero length", fb);
  endtask

  task automatic random_back_to_back();
    int fb;
    int k;
    int i;
    fb = fail_count;
    for (k = 0; k < num_random; k++) begin
      lens[k] = int'($urandom_range(max_len));
    end
    for (k = 0; k < num_random; k++) begin
      for (i = 0; i < lens[k]; i++) begin
        vals[i] = int'($urandom_range(4094)) - 2047;
      end
      run_sum(lens[k], 3, 6, (k < num_random - 1) ? lens[k + 1] : -1);
    end
    report_test("random back-to-back", fb);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    seed_val   = $urandom(32'h52ac_8648);
    pass_count = 0;
    fail_count = 0;
    RST        <= 1'b1;
    length     <= '0;
    start_req  <= 1'b0;
    data_in    <= '0;
    data_req   <= 1'b0;
    sum_ack    <= 1'b0;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;
    reset_levels();
    single_item();
    eight_positive();
    mixed_signs();
    zero_length();
    random_back_to_back();
    $display("Checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/tensor_summation.sv
`timescale 1ns/1ns
////////////////////////////////////////
// Tensor summation engine top
////////////////////////////////////////
`include "tensor_sum_defs.svh"

module tensor_summation (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic [`TS_LENGTH_WIDTH-1:0] length,
  input  logic                        start_req,
  output logic                        start_ack,
  input  tensor_sum_pkg::float_t      data_in,
  input  logic                        data_req,
  output logic                        data_ack,
  output tensor_sum_pkg::float_t      sum_out,
  output logic                        sum_req,
  input  logic                        sum_ack
);

  // Dispatcher to lanes
  tensor_sum_pkg::float_t lane_item;
  logic [1:0]             lane_load;
  logic                   clear;
  logic                   flush;

  // Lanes to dispatcher and combiner
  logic [1:0]             lane_busy;
  logic [1:0]             lane_done;
  tensor_sum_pkg::float_t partial_0;
  tensor_sum_pkg::float_t partial_1;

  // Combiner back to dispatcher
  logic                   run_done;

  stream_dispatcher i_stream_dispatcher (
    .CLK       (CLK),
    .RST       (RST),
    .length    (length),
    .start_req (start_req),
    .start_ack (start_ack),
    .data_in   (data_in),
    .data_req  (data_req),
    .data_ack  (data_ack),
    .lane_busy (lane_busy),
    .lane_item (lane_item),
    .lane_load (lane_load),
    .clear     (clear),
    .flush     (flush),
    .run_done  (run_done)
  );

  // Even items
  partial_accumulator i_lane_0 (
    .CLK     (CLK),
    .RST     (RST),
    .clear   (clear),
    .load    (lane_load[0]),
    .item    (lane_item),
    .flush   (flush),
    .busy    (lane_busy[0]),
    .done    (lane_done[0]),
    .partial (partial_0)
  );

  // Odd items
  partial_accumulator i_lane_1 (
    .CLK     (CLK),
    .RST     (RST),
    .clear   (clear),
    .load    (lane_load[1]),
    .item    (lane_item),
    .flush   (flush),
    .busy    (lane_busy[1]),
    .done    (lane_done[1]),
    .partial (partial_1)
  );

  sum_combiner i_sum_combiner (
    .CLK       (CLK),
    .RST       (RST),
    .done      (lane_done),
    .partial_0 (partial_0),
    .partial_1 (partial_1),
    .sum_out   (sum_out),
    .sum_req   (sum_req),
    .sum_ack   (sum_ack),
    .run_done  (run_done)
  );

endmodule

// File: verilog/sum_combiner.sv
`timescale 1ns/1ns
////////////////////////////////////////
// Final add of both lane sums and the
// result handshake
////////////////////////////////////////

module sum_combiner (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic [1:0]             done,
  input  tensor_sum_pkg::float_t partial_0,
  input  tensor_sum_pkg::float_t partial_1,
  output tensor_sum_pkg::float_t sum_out,
  output logic                   sum_req,
  input  logic                   sum_ack,
  output logic                   run_done
);

  localparam logic [2:0] st_idle    = 3'd0;
  localparam logic [2:0] st_add     = 3'd1;
  localparam logic [2:0] st_req     = 3'd2;
  localparam logic [2:0] st_release = 3'd3;
  localparam logic [2:0] st_drain   = 3'd4;

  logic [2:0]             state;
  logic                   add_start;
  logic                   add_ready;
  tensor_sum_pkg::float_t add_result;

  // Lane sums stay put while done is high
  float_adder i_float_adder (
    .CLK    (CLK),
    .RST    (RST),
    .start  (add_start),
    .a      (partial_0),
    .b      (partial_1),
    .ready  (add_ready),
    .result (add_result)
  );

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= st_idle;
      add_start <= 1'b0;
      sum_req   <= 1'b0;
      run_done  <= 1'b0;
    end else begin
      add_start <= 1'b0;
      run_done  <= 1'b0;
      case (state)
        st_idle: begin
          if (&done) begin
            add_start <= 1'b1;
            state     <= st_add;
          end
        end
        st_add: begin
          if (add_ready) begin
            sum_req <= 1'b1;
            state   <= st_req;
          end
        end
        st_req: begin
          if (sum_ack) begin
            sum_req <= 1'b0;
            state   <= st_release;
          end
        end
        // Free the dispatcher once ack is down
        st_release: begin
          if (!sum_ack) begin
            run_done <= 1'b1;
            state    <= st_drain;
          end
        end
        // Stale done levels until the next clear
        st_drain: begin
          if (!(&done)) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (add_ready) begin
      sum_out <= add_result;
    end
  end

  // Host may sample sum_out any time req is up
  a_sum_stable: assert property (@(posedge CLK) disable iff (RST)
    sum_req |=> !sum_req || $stable(sum_out));

endmodule

// File: verilog/partial_accumulator.sv
`timescale 1ns/1ns
////////////////////////////////////////
// One summation lane, running sum kept
// through its own float adder
////////////////////////////////////////

module partial_accumulator (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   clear,
  input  logic                   load,
  input  tensor_sum_pkg::float_t item,
  input  logic                   flush,
  output logic                   busy,
  output logic                   done,
  output tensor_sum_pkg::float_t partial
);

  logic                   add_ready;
  tensor_sum_pkg::float_t add_result;
  // Flush seen while an add was running
  logic                   flush_pend;
  // Adder still running past this cycle
  logic                   add_open;

  assign add_open = (busy && !add_ready) || load;

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  // Item is held by the dispatcher during load
  float_adder i_float_adder (
    .CLK    (CLK),
    .RST    (RST),
    .start  (load),
    .a      (partial),
    .b      (item),
    .ready  (add_ready),
    .result (add_result)
  );

  ////////////////////////////////////////
  // Lane state
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy       <= 1'b0;
      done       <= 1'b0;
      flush_pend <= 1'b0;
    end else begin
      if (load) begin
        busy <= 1'b1;
      end else if (add_ready) begin
        busy <= 1'b0;
      end
      if (clear) begin
        done       <= 1'b0;
        flush_pend <= 1'b0;
      end else if (flush) begin
        // Done now if idle, else after the final ready
        if (add_open) begin
          flush_pend <= 1'b1;
        end else begin
          done <= 1'b1;
        end
      end else if (flush_pend && add_ready) begin
        flush_pend <= 1'b0;
        done       <= 1'b1;
      end
    end
  end

  // Running sum starts at +0 on each command
  always_ff @(posedge CLK) begin
    if (clear) begin
      partial <= '0;
    end else if (add_ready) begin
      partial <= add_result;
    end
  end

endmodule

// File: verilog/stream_dispatcher.sv
`timescale 1ns/1ns
////////////////////////////////////////
// Command and data handshakes, item
// count and even/odd lane steering
////////////////////////////////////////
`include "tensor_sum_defs.svh"

module stream_dispatcher (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic [`TS_LENGTH_WIDTH-1:0]  length,
  input  logic                         start_req,
  output logic                         start_ack,
  input  tensor_sum_pkg::float_t       data_in,
  input  logic                         data_req,
  output logic                         data_ack,
  input  logic [1:0]                   lane_busy,
  output tensor_sum_pkg::float_t       lane_item,
  output logic [1:0]                   lane_load,
  output logic                         clear,
  output logic                         flush,
  input  logic                         run_done
);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_run   = 2'd1;
  localparam logic [1:0] st_flush = 2'd2;
  localparam logic [1:0] st_wait  = 2'd3;

  logic [1:0]                  state;
  logic [`TS_LENGTH_WIDTH-1:0] len_r;
  logic [`TS_LENGTH_WIDTH-1:0] count;
  logic                        take;

  // Low index bit picks the lane
  assign take = (state == st_run) && data_req && !data_ack && !lane_busy[count[0]];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= st_idle;
      start_ack <= 1'b0;
      data_ack  <= 1'b0;
      lane_load <= 2'b00;
      clear     <= 1'b0;
      flush     <= 1'b0;
      len_r     <= '0;
      count     <= '0;
    end else begin
      lane_load <= 2'b00;
      clear     <= 1'b0;
      flush     <= 1'b0;
      // Command ack follows req down
      if (start_ack && !start_req) begin
        start_ack <= 1'b0;
      end
      case (state)
        st_idle: begin
          if (start_req && !start_ack) begin
            start_ack <= 1'b1;
            clear     <= 1'b1;
            len_r     <= length;
            count     <= '0;
            state     <= (length == '0) ? st_flush : st_run;
          end
        end
        st_run: begin
          if (take) begin
            data_ack             <= 1'b1;
            lane_load[count[0]]  <= 1'b1;
            count                <= count + 1'b1;
          end else if (data_ack && !data_req) begin
            data_ack <= 1'b0;
            // Last item fully handed over
            if (count == len_r) begin
              state <= st_flush;
            end
          end
        end
        st_flush: begin
          flush <= 1'b1;
          state <= st_wait;
        end
        // Held here until the result handshake ends
        st_wait: begin
          if (run_done) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (take) begin
      lane_item <= data_in;
    end
  end

  // Lane busy comes back from the accumulators
  a_load_free: assert property (@(posedge CLK) disable iff (RST)
    (lane_load & lane_busy) == 2'b00);

endmodule

// File: verilog/float_adder.sv
`timescale 1ns/1ns
////////////////////////////////////////
// Multi-cycle float adder, serial align
// and normalize, truncating, FTZ inputs
////////////////////////////////////////
`include "tensor_sum_defs.svh"

module float_adder (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   start,
  input  tensor_sum_pkg::float_t a,
  input  tensor_sum_pkg::float_t b,
  output logic                   ready,
  output tensor_sum_pkg::float_t result
);

  // Mantissa with hidden bit
  localparam int man_w = `TS_MANT_WIDTH + 1;
  // Past this many shifts the small operand is gone
  localparam logic [4:0] shift_max = 5'(man_w);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_align = 2'd1;
  localparam logic [1:0] st_add   = 2'd2;
  localparam logic [1:0] st_norm  = 2'd3;

  logic [1:0] state;
  logic [4:0] shift_cnt;
  logic [4:0] shift_init;

  // Operand unpack
  logic                     a_zero;
  logic                     b_zero;
  logic                     a_big;
  logic [man_w-1:0]         man_a;
  logic [man_w-1:0]         man_b;
  logic [`TS_EXP_WIDTH-1:0] exp_big;
  logic [`TS_EXP_WIDTH-1:0] exp_small;
  logic [`TS_EXP_WIDTH-1:0] exp_diff;

  // Working registers
  logic                     sign_big;
  logic                     sign_small;
  logic [man_w-1:0]         man_big;
  logic [man_w-1:0]         man_small;
  logic [`TS_EXP_WIDTH-1:0] exp_r;
  logic [man_w:0]           sum_man;
  logic                     sum_sign;

  // Normalize decisions
  logic norm_zero;
  logic norm_carry;
  logic norm_ok;
  logic norm_under;

  ////////////////////////////////////////
  // Unpack and order
  ////////////////////////////////////////

  // Zero exponent flushes zero and subnormal alike
  assign a_zero = (a.f.exp == '0);
  assign b_zero = (b.f.exp == '0);
  assign man_a  = a_zero ? '0 : {1'b1, a.f.mant};
  assign man_b  = b_zero ? '0 : {1'b1, b.f.mant};

  // Larger exponent is the reference
  assign a_big     = (a.f.exp >= b.f.exp);
  assign exp_big   = a_big ? a.f.exp : b.f.exp;
  assign exp_small = a_big ? b.f.exp : a.f.exp;
  assign exp_diff  = exp_big - exp_small;

  // No shifting for a zero small operand
  assign shift_init = (exp_small == '0) ? 5'd0 :
                      (exp_diff > 8'(shift_max)) ? shift_max : exp_diff[4:0];

  // Bit man_w is the carry of an add
  assign norm_zero  = (sum_man == '0);
  assign norm_carry = sum_man[man_w];
  assign norm_ok    = !norm_carry && sum_man[man_w-1];
  // Left shift would go subnormal
  assign norm_under = !norm_zero && !norm_carry && !sum_man[man_w-1] &&
                      (exp_r[`TS_EXP_WIDTH-1:1] == '0);

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= st_idle;
      shift_cnt <= '0;
      ready     <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            shift_cnt <= shift_init;
            state     <= (shift_init == '0) ? st_add : st_align;
          end
        end
        st_align: begin
          shift_cnt <= shift_cnt - 1'b1;
          if (shift_cnt == 5'd1) begin
            state <= st_add;
          end
        end
        st_add: state <= st_norm;
        st_norm: begin
          // One shift per cycle until done
          if (norm_zero || norm_ok || norm_under) begin
            ready <= 1'b1;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      st_idle: begin
        if (start) begin
          sign_big   <= a_big ? a.f.sign : b.f.sign;
          sign_small <= a_big ? b.f.sign : a.f.sign;
          man_big    <= a_big ? man_a : man_b;
          man_small  <= a_big ? man_b : man_a;
          exp_r      <= exp_big;
        end
      end
      // Bits shifted out are truncated
      st_align: man_small <= man_small >> 1;
      st_add: begin
        if (sign_big == sign_small) begin
          sum_man  <= {1'b0, man_big} + {1'b0, man_small};
          sum_sign <= sign_big;
        end else if (man_big >= man_small) begin
          sum_man  <= {1'b0, man_big - man_small};
          sum_sign <= sign_big;
        end else begin
          sum_man  <= {1'b0, man_small - man_big};
          sum_sign <= sign_small;
        end
      end
      st_norm: begin
        if (norm_zero || norm_under) begin
          // Exact zero and underflow both give +0
          result.bits <= '0;
        end else if (norm_ok) begin
          result.f.sign <= sum_sign;
          result.f.exp  <= exp_r;
          result.f.mant <= sum_man[`TS_MANT_WIDTH-1:0];
        end else if (norm_carry) begin
          sum_man <= sum_man >> 1;
          exp_r   <= exp_r + 1'b1;
        end else begin
          sum_man <= sum_man << 1;
          exp_r   <= exp_r - 1'b1;
        end
      end
      default: ;
    endcase
  end

  // Owner must wait for ready before starting again
  a_start_idle: assert property (@(posedge CLK) disable iff (RST)
    start |-> (state == st_idle));

endmodule

// File: verilog/tensor_sum_pkg.sv
////////////////////////////////////////
// Tensor summation shared types
// Float word seen as bits or as fields
////////////////////////////////////////
`include "tensor_sum_defs.svh"

package tensor_sum_pkg;

  ////////////////////////////////////////
  // Float layout
  ////////////////////////////////////////

  // Sign, biased exponent, stored mantissa
  // MSB first like the IEEE word
  typedef struct packed {
    logic                      sign;
    logic [`TS_EXP_WIDTH-1:0]  exp;
    logic [`TS_MANT_WIDTH-1:0] mant;
  } float_fields_t;

  // Raw view for moving words around
  // Field view for the adders
  typedef union packed {
    logic [`TS_FLOAT_WIDTH-1:0] bits;
    float_fields_t              f;
  } float_t;

endpackage

// File: include/tensor_sum_defs.svh
////////////////////////////////////////
// Tensor summation widths and the
// single-precision float format
////////////////////////////////////////
`ifndef TENSOR_SUM_DEFS_SVH
`define TENSOR_SUM_DEFS_SVH

// One float word
`define TS_FLOAT_WIDTH 32

// Field widths without the hidden bit
`define TS_EXP_WIDTH 8
`define TS_MANT_WIDTH 23
`define TS_EXP_BIAS 127

// Item count of one command
`define TS_LENGTH_WIDTH 16

`endif
